/* verilog/mcalc_pkg.sv */
package mcalc_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int MAX_TYPES = 25;         // ledger entries, one per shape

    typedef logic [2:0] dim_t;             // matrix side, 1..5
    typedef logic [8:0] addr_t;
    typedef logic [3:0] scalar_t;
    typedef logic [4:0] type_idx_t;
    typedef logic [1:0] slot_cnt_t;        // valid slots per shape, 0..2
    typedef logic [7:0] id_t;

    // ========================================
    // operation codes
    // ========================================
    typedef logic [2:0] opcode_t;

    localparam opcode_t OP_TRANSPOSE  = 3'd0;
    localparam opcode_t OP_ADD        = 3'd1;
    localparam opcode_t OP_SCALAR_MUL = 3'd2;
    localparam opcode_t OP_MATMUL     = 3'd3;  // codes above 3 act as matmul too

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_INPUT      = 4'd1,
        ST_SELECT_OP  = 4'd2,
        ST_GET_DIM    = 4'd3,
        ST_FILTER     = 4'd4,
        ST_GET_ID     = 4'd5,
        ST_GET_SCALAR = 4'd6,
        ST_CHECK      = 4'd7,
        ST_EXECUTE    = 4'd8,
        ST_DECISION   = 4'd9,
        ST_ERROR      = 4'd10
    } ctrl_state_t;

endpackage

/* verilog/ledger_if.sv */
`timescale 1ns/100ps

interface ledger_if import mcalc_pkg::*; ();

    // query and requests, from the sequencer
    dim_t      q_m;
    dim_t      q_n;
    logic      alloc;      // allocate q_m x q_n
    logic      cancel;     // undo the last allocation

    // lookup result, combinational from the query
    logic      hit;
    addr_t     hit_start;
    slot_cnt_t hit_cnt;
    addr_t     slot_addr;

    modport seq (
        output q_m, q_n, alloc, cancel,
        input  hit, hit_start, hit_cnt, slot_addr
    );

    modport book (
        input  q_m, q_n, alloc, cancel,
        output hit, hit_start, hit_cnt, slot_addr
    );

endinterface

/* verilog/key_edge_decoder.sv */
`timescale 1ns/100ps

module key_edge_decoder (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] i_btn,      // 0 confirm, 1 retry, 2 menu
    output logic       o_confirm,
    output logic       o_retry,
    output logic       o_menu
);

    logic [2:0] btn_now;
    logic [2:0] btn_prev;
    logic [2:0] rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_now  <= '0;
            btn_prev <= '0;
        end else begin
            btn_now  <= i_btn;
            btn_prev <= btn_now;
        end
    end

    assign rise = btn_now & ~btn_prev;  // high one cycle per press

    assign o_confirm = rise[0];
    assign o_retry   = rise[1];
    assign o_menu    = rise[2];

endmodule

/* verilog/matrix_ledger.sv */
`timescale 1ns/100ps

module matrix_ledger import mcalc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    ledger_if.book    bus,
    output type_idx_t o_types_count
);

    // shape table
    dim_t      ent_m     [MAX_TYPES];
    dim_t      ent_n     [MAX_TYPES];
    addr_t     ent_start [MAX_TYPES];
    logic      ent_tog   [MAX_TYPES];   // which of the two slots is written next
    slot_cnt_t ent_cnt   [MAX_TYPES];

    type_idx_t type_cnt;
    addr_t     free_ptr;
    type_idx_t hit_idx;
    logic      found;
    logic      full;
    logic      do_hit;
    logic      do_new;
    logic      undo;
    addr_t     shape_size;

    // state saved by the open allocation
    logic      bk_open;
    logic      bk_new;
    type_idx_t bk_idx;
    slot_cnt_t bk_cnt;
    addr_t     bk_free;

    // ========================================
    // lookup
    // ========================================
    always_comb begin
        found   = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < MAX_TYPES; i++) begin
            if (type_idx_t'(i) < type_cnt && ent_m[i] == bus.q_m && ent_n[i] == bus.q_n) begin
                found   = 1'b1;
                hit_idx = type_idx_t'(i);
            end
        end
    end

    assign shape_size = addr_t'(bus.q_m) * addr_t'(bus.q_n);
    assign full       = (type_cnt == type_idx_t'(MAX_TYPES));

    assign bus.hit       = found && (ent_cnt[hit_idx] != '0);
    assign bus.hit_start = found ? ent_start[hit_idx] : '0;
    assign bus.hit_cnt   = found ? ent_cnt[hit_idx] : '0;
    assign bus.slot_addr = !found           ? free_ptr :
                           ent_tog[hit_idx] ? ent_start[hit_idx] + shape_size :
                                              ent_start[hit_idx];

    assign do_hit = bus.alloc && found;
    assign do_new = bus.alloc && !found && !full;   // full table drops the miss
    assign undo   = bus.cancel && bk_open && !bus.alloc;

    // ========================================
    // allocation and rollback
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            type_cnt <= '0;
            free_ptr <= '0;
            bk_open  <= 1'b0;
        end else if (bus.alloc) begin
            bk_open <= do_hit || do_new;
            if (do_new) begin
                type_cnt <= type_cnt + 1'b1;
                free_ptr <= free_ptr + (shape_size << 1);  // two slots per shape
            end
        end else if (undo) begin
            bk_open <= 1'b0;
            if (bk_new) begin
                type_cnt <= type_cnt - 1'b1;
                free_ptr <= bk_free;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_new) begin
            ent_m[type_cnt]     <= bus.q_m;
            ent_n[type_cnt]     <= bus.q_n;
            ent_start[type_cnt] <= free_ptr;
            ent_tog[type_cnt]   <= 1'b1;
            ent_cnt[type_cnt]   <= 2'd1;
            bk_new              <= 1'b1;
            bk_free             <= free_ptr;
        end else if (do_hit) begin
            ent_tog[hit_idx] <= ~ent_tog[hit_idx];
            if (ent_cnt[hit_idx] < 2'd2) ent_cnt[hit_idx] <= ent_cnt[hit_idx] + 2'd1;
            bk_new <= 1'b0;
            bk_idx <= hit_idx;
            bk_cnt <= ent_cnt[hit_idx];
        end else if (undo && !bk_new) begin
            ent_tog[bk_idx] <= ~ent_tog[bk_idx];
            ent_cnt[bk_idx] <= bk_cnt;
        end
    end

    assign o_types_count = type_cnt;

endmodule

/* verilog/calc_sequencer.sv */
`timescale 1ns/100ps

module calc_sequencer import mcalc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_confirm,
    input  logic        i_retry,
    input  logic        i_menu,
    input  logic [7:0]  i_sw,
    input  logic        i_dims_valid,
    input  dim_t        i_dim_m,
    input  dim_t        i_dim_n,
    input  logic        i_rx_done,
    input  logic        i_error_flag,
    input  logic        i_timeout,
    input  id_t         i_id_val,
    input  logic        i_id_valid,
    input  logic        i_calc_done,
    ledger_if.seq       bus,
    output logic        o_en_input,
    output logic [1:0]  o_task_mode,
    output logic        o_addr_ready,
    output addr_t       o_base_addr,
    output logic        o_start_calc,
    output opcode_t     o_op_code,
    output addr_t       o_op1_addr,
    output addr_t       o_op2_addr,
    output dim_t        o_op1_m,
    output dim_t        o_op1_n,
    output dim_t        o_op2_m,
    output dim_t        o_op2_n,
    output scalar_t     o_scalar,
    output addr_t       o_res_addr,
    output ctrl_state_t o_state,
    output logic        o_logic_error
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t retry_st;
    opcode_t     op;
    logic        stage;        // 0 while picking operand 1
    logic        alloc_open;
    dim_t        cur_m, cur_n, op1_m, op1_n, op2_m, op2_n, res_m, res_n;
    addr_t       op1_addr, op2_addr, pick_addr;
    scalar_t     scalar;
    logic        first_dims, id_ok, shape_ok;

    assign o_state    = state;
    assign first_dims = (state == ST_INPUT) && i_dims_valid && !o_addr_ready;
    assign id_ok      = (i_id_val != '0) && (i_id_val <= id_t'(bus.hit_cnt));
    assign pick_addr  = bus.hit_start
                      + addr_t'(i_id_val - 8'd1) * addr_t'(cur_m) * addr_t'(cur_n);

    assign bus.alloc  = first_dims || (state == ST_EXECUTE && i_calc_done);
    assign bus.cancel = (state == ST_INPUT) && alloc_open && i_error_flag && !i_rx_done;

    // shape check and result shape
    always_comb begin
        shape_ok       = 1'b1;
        {res_m, res_n} = {op1_m, op1_n};
        case (op)
            OP_TRANSPOSE:  {res_m, res_n} = {op1_n, op1_m};
            OP_ADD:        shape_ok = (op1_m == op2_m) && (op1_n == op2_n);
            OP_SCALAR_MUL: shape_ok = 1'b1;
            default: begin
                shape_ok       = (op1_n == op2_m);
                {res_m, res_n} = {op1_m, op2_n};
            end
        endcase
    end

    always_comb begin
        if (state == ST_INPUT) {bus.q_m, bus.q_n} = {i_dim_m, i_dim_n};
        else if (state == ST_EXECUTE) {bus.q_m, bus.q_n} = {res_m, res_n};
        else {bus.q_m, bus.q_n} = {cur_m, cur_n};
    end

    // ========================================
    // next state
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (i_confirm && i_sw[1:0] == 2'b00) next_state = ST_INPUT;
                else if (i_confirm && i_sw[1:0] == 2'b10) next_state = ST_SELECT_OP;
            ST_INPUT:
                if (i_rx_done) next_state = ST_DECISION;
                else if (i_timeout) next_state = ST_ERROR;
            ST_SELECT_OP:
                if (i_confirm) next_state = ST_GET_DIM;
            ST_GET_DIM:
                if (i_dims_valid) next_state = ST_FILTER;
            ST_FILTER:
                next_state = bus.hit ? ST_GET_ID : ST_ERROR;
            ST_GET_ID:
                if (i_id_valid && id_ok) begin
                    if (stage || op == OP_TRANSPOSE) next_state = ST_CHECK;
                    else if (op == OP_SCALAR_MUL) next_state = ST_GET_SCALAR;
                    else next_state = ST_GET_DIM;
                end
            ST_GET_SCALAR:
                if (i_confirm) next_state = ST_CHECK;
            ST_CHECK:
                next_state = shape_ok ? ST_EXECUTE : ST_ERROR;
            ST_EXECUTE:
                if (i_calc_done) next_state = ST_DECISION;
            ST_DECISION:
                if (i_confirm) next_state = ST_IDLE;
                else if (i_retry) next_state = retry_st;
            ST_ERROR:
                if (i_confirm) next_state = ST_IDLE;
            default: next_state = ST_IDLE;
        endcase
        if (i_menu) next_state = ST_IDLE;  // menu wins from anywhere
    end

    // ========================================
    // control registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            retry_st      <= ST_IDLE;
            stage         <= 1'b0;
            alloc_open    <= 1'b0;
            o_en_input    <= 1'b0;
            o_task_mode   <= 2'd0;
            o_addr_ready  <= 1'b0;
            o_start_calc  <= 1'b0;
            o_logic_error <= 1'b0;
        end else begin
            state        <= next_state;
            o_en_input   <= next_state inside {ST_INPUT, ST_GET_DIM, ST_GET_ID};
            o_addr_ready <= (state == ST_INPUT) && (next_state == ST_INPUT) && i_dims_valid;
            o_start_calc <= (state == ST_EXECUTE) && (next_state == ST_EXECUTE);
            alloc_open   <= (state == ST_INPUT) && (alloc_open || first_dims)
                          && !bus.cancel && !i_rx_done;
            case (next_state)
                ST_GET_DIM: o_task_mode <= 2'd1;  // shape entry
                ST_GET_ID:  o_task_mode <= 2'd2;  // id entry
                default:    o_task_mode <= 2'd0;
            endcase
            if (state == ST_IDLE && next_state != ST_IDLE) retry_st <= next_state;
            if (state == ST_SELECT_OP) stage <= 1'b0;
            else if (state == ST_GET_ID && next_state == ST_GET_DIM) stage <= 1'b1;
            if (state == ST_IDLE || state == ST_SELECT_OP) o_logic_error <= 1'b0;
            else if (state == ST_FILTER && !bus.hit) o_logic_error <= 1'b1;
            else if (state == ST_CHECK && !shape_ok) o_logic_error <= 1'b1;
            else if (state == ST_GET_ID && i_id_valid) o_logic_error <= !id_ok;
        end
    end

    // operands and core outputs
    always_ff @(posedge clk) begin
        if (first_dims) o_base_addr <= bus.slot_addr;
        if (state == ST_SELECT_OP && i_confirm) op <= i_sw[7:5];
        if (state == ST_GET_DIM && i_dims_valid) {cur_m, cur_n} <= {i_dim_m, i_dim_n};
        if (state == ST_GET_ID && i_id_valid && id_ok) begin
            if (!stage) begin
                op1_addr       <= pick_addr;
                {op1_m, op1_n} <= {cur_m, cur_n};
            end else begin
                op2_addr       <= pick_addr;
                {op2_m, op2_n} <= {cur_m, cur_n};
            end
        end
        if (state == ST_GET_SCALAR && i_confirm) scalar <= i_sw[7:4];
        if (state == ST_EXECUTE) begin
            o_op_code  <= op;
            o_op1_addr <= op1_addr;
            o_op2_addr <= op2_addr;
            o_op1_m    <= op1_m;
            o_op1_n    <= op1_n;
            o_op2_m    <= op2_m;
            o_op2_n    <= op2_n;
            o_scalar   <= scalar;
            o_res_addr <= bus.slot_addr;   // result shape is on the query
        end
    end

endmodule

/* verilog/matrix_ctrl_top.sv */
`timescale 1ns/100ps

module matrix_ctrl_top import mcalc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  i_sw,
    input  logic [2:0]  i_btn,
    input  logic        i_dims_valid,
    input  dim_t        i_dim_m,
    input  dim_t        i_dim_n,
    input  logic        i_rx_done,
    input  logic        i_error_flag,
    input  logic        i_timeout,
    input  id_t         i_id_val,
    input  logic        i_id_valid,
    input  logic        i_calc_done,
    output logic        o_en_input,
    output logic [1:0]  o_task_mode,
    output logic        o_addr_ready,
    output addr_t       o_base_addr,
    output logic        o_start_calc,
    output opcode_t     o_op_code,
    output addr_t       o_op1_addr,
    output addr_t       o_op2_addr,
    output dim_t        o_op1_m,
    output dim_t        o_op1_n,
    output dim_t        o_op2_m,
    output dim_t        o_op2_n,
    output scalar_t     o_scalar,
    output addr_t       o_res_addr,
    output type_idx_t   o_types_count,
    output ctrl_state_t o_state,
    output logic        o_logic_error
);

    logic confirm;
    logic retry;
    logic menu;

    ledger_if lif ();

    key_edge_decoder u_keys (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_btn     (i_btn),
        .o_confirm (confirm),
        .o_retry   (retry),
        .o_menu    (menu)
    );

    calc_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_confirm     (confirm),
        .i_retry       (retry),
        .i_menu        (menu),
        .i_sw          (i_sw),
        .i_dims_valid  (i_dims_valid),
        .i_dim_m       (i_dim_m),
        .i_dim_n       (i_dim_n),
        .i_rx_done     (i_rx_done),
        .i_error_flag  (i_error_flag),
        .i_timeout     (i_timeout),
        .i_id_val      (i_id_val),
        .i_id_valid    (i_id_valid),
        .i_calc_done   (i_calc_done),
        .bus           (lif.seq),
        .o_en_input    (o_en_input),
        .o_task_mode   (o_task_mode),
        .o_addr_ready  (o_addr_ready),
        .o_base_addr   (o_base_addr),
        .o_start_calc  (o_start_calc),
        .o_op_code     (o_op_code),
        .o_op1_addr    (o_op1_addr),
        .o_op2_addr    (o_op2_addr),
        .o_op1_m       (o_op1_m),
        .o_op1_n       (o_op1_n),
        .o_op2_m       (o_op2_m),
        .o_op2_n       (o_op2_n),
        .o_scalar      (o_scalar),
        .o_res_addr    (o_res_addr),
        .o_state       (o_state),
        .o_logic_error (o_logic_error)
    );

    matrix_ledger u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus           (lif.book),
        .o_types_count (o_types_count)
    );

endmodule

/* tb/matrix_ctrl_checker.sv */
`timescale 1ns/100ps

module matrix_ctrl_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_req,
    input  logic [3:0]  i_sel,
    input  logic [15:0] i_exp,
    input  logic [3:0]  i_state,
    input  logic [8:0]  i_base_addr,
    input  logic [4:0]  i_types_count,
    input  logic        i_logic_error,
    input  logic [8:0]  i_op1_addr,
    input  logic [8:0]  i_op2_addr,
    input  logic [8:0]  i_res_addr,
    input  logic        i_start_calc,
    input  logic [3:0]  i_scalar,
    input  logic [2:0]  i_op_code,
    input  logic [2:0]  i_op1_m,
    input  logic [2:0]  i_op1_n,
    input  logic [2:0]  i_op2_m,
    input  logic [2:0]  i_op2_n,
    input  logic        i_en_input,
    input  logic [1:0]  i_task_mode,
    input  logic        i_calc_done,
    output int          o_errors,
    output int          o_checks
);

    logic        start_prev = 1'b0;
    logic        done_prev = 1'b0;
    logic [15:0] got;
    string       name;

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    always_comb begin
        case (i_sel)
            4'h0: begin got = 16'(i_state);       name = "o_state";       end
            4'h1: begin got = 16'(i_base_addr);   name = "o_base_addr";   end
            4'h2: begin got = 16'(i_types_count); name = "o_types_count"; end
            4'h3: begin got = 16'(i_logic_error); name = "o_logic_error"; end
            4'h4: begin got = 16'(i_op1_addr);    name = "o_op1_addr";    end
            4'h5: begin got = 16'(i_op2_addr);    name = "o_op2_addr";    end
            4'h6: begin got = 16'(i_res_addr);    name = "o_res_addr";    end
            4'h7: begin got = 16'(i_start_calc);  name = "o_start_calc";  end
            4'h8: begin got = 16'(i_scalar);      name = "o_scalar";      end
            4'h9: begin got = 16'(i_op_code);     name = "o_op_code";     end
            4'ha: begin got = 16'(i_op1_m);       name = "o_op1_m";       end
            4'hb: begin got = 16'(i_op1_n);       name = "o_op1_n";       end
            4'hc: begin got = 16'(i_op2_m);       name = "o_op2_m";       end
            4'hd: begin got = 16'(i_op2_n);       name = "o_op2_n";       end
            4'he: begin got = 16'(i_en_input);    name = "o_en_input";    end
            4'hf: begin got = 16'(i_task_mode);   name = "o_task_mode";   end
        endcase
    end

    // compare mid-cycle, away from the drive edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (i_req) begin
                o_checks++;
                if (got != i_exp) begin
                    o_errors++;
                    $display("ERR %s got 0x%0h expected 0x%0h", name, got, i_exp);
                end
            end
            if (start_prev && !i_start_calc && !done_prev) begin
                o_errors++;
                $display("core request dropped before the core reported done");
            end
            start_prev <= i_start_calc;
            done_prev  <= i_calc_done;
        end
    end

endmodule

/* tb/matrix_ctrl_properties.sv */
`timescale 1ns/100ps

module matrix_ctrl_properties import mcalc_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] i_state,
    input logic       i_addr_ready,
    input logic       i_start_calc
);

    a_ready_in_input: assert property (@(posedge clk) disable iff (!rst_n)
        i_addr_ready |-> i_state == ST_INPUT)
        else $error("address ready outside input mode");

    a_start_in_exec: assert property (@(posedge clk) disable iff (!rst_n)
        i_start_calc |-> i_state == ST_EXECUTE)
        else $error("core request outside execute state");

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        i_state <= ST_ERROR)
        else $error("state register left the enum range");

endmodule

bind calc_sequencer matrix_ctrl_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_state      (state),
    .i_addr_ready (o_addr_ready),
    .i_start_calc (o_start_calc)
);

/* tb/tb_matrix_ctrl.sv */
`timescale 1ns/100ps

module tb_matrix_ctrl;

    localparam int CYCLES_PER_CMD = 200;

    // checker selects beyond the ones used in the data file
    localparam int SEL_OP2_M     = 'hc;
    localparam int SEL_OP2_N     = 'hd;
    localparam int SEL_EN_INPUT  = 'he;
    localparam int SEL_TASK_MODE = 'hf;

    // input subsystem task codes
    localparam int TASK_SHAPE = 1;
    localparam int TASK_ID    = 2;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_sw;
    logic [2:0]  i_btn;
    logic        i_dims_valid;
    logic [2:0]  i_dim_m;
    logic [2:0]  i_dim_n;
    logic        i_rx_done;
    logic        i_error_flag;
    logic        i_timeout;
    logic [7:0]  i_id_val;
    logic        i_id_valid;
    logic        i_calc_done;
    logic        o_en_input, o_addr_ready, o_start_calc, o_logic_error;
    logic [1:0]  o_task_mode;
    logic [8:0]  o_base_addr, o_op1_addr, o_op2_addr, o_res_addr;
    logic [2:0]  o_op_code, o_op1_m, o_op1_n, o_op2_m, o_op2_n;
    logic [3:0]  o_scalar;
    logic [4:0]  o_types_count;
    logic [3:0]  o_state;

    logic        chk_req;
    logic [3:0]  chk_sel;
    logic [15:0] chk_exp;
    int          chk_errs;
    int          chk_total;

    int cmd_op[$];
    int cmd_a[$];
    int cmd_b[$];
    int cycle_limit = 0;
    int cycles = 0;

    // operand shapes picked since the last calculation
    int pick_m[2];
    int pick_n[2];
    int picks = 0;

    matrix_ctrl_top i_dut (.*);

    matrix_ctrl_checker u_chk (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req         (chk_req),
        .i_sel         (chk_sel),
        .i_exp         (chk_exp),
        .i_state       (o_state),
        .i_base_addr   (o_base_addr),
        .i_types_count (o_types_count),
        .i_logic_error (o_logic_error),
        .i_op1_addr    (o_op1_addr),
        .i_op2_addr    (o_op2_addr),
        .i_res_addr    (o_res_addr),
        .i_start_calc  (o_start_calc),
        .i_scalar      (o_scalar),
        .i_op_code     (o_op_code),
        .i_op1_m       (o_op1_m),
        .i_op1_n       (o_op1_n),
        .i_op2_m       (o_op2_m),
        .i_op2_n       (o_op2_n),
        .i_en_input    (o_en_input),
        .i_task_mode   (o_task_mode),
        .i_calc_done   (i_calc_done),
        .o_errors      (chk_errs),
        .o_checks      (chk_total)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit scales with the number of commands
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: no progress within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ========================================
    // helpers
    // ========================================
    task automatic load_commands(output int count);
        int fd;
        int r;
        int c, a, b;
        string line;
        count = -1;
        fd = $fopen("tb/matrix_ctrl_testdata.txt", "r");
        if (fd != 0) begin
            count = 0;
            while (!$feof(fd)) begin
                line = "";
                r = $fgets(line, fd);
                r = $sscanf(line, "%h %h %h", c, a, b);
                if (r == 3) begin   // comment and blank lines give no fields
                    cmd_op.push_back(c);
                    cmd_a.push_back(a);
                    cmd_b.push_back(b);
                    count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic arm_check(input int sel, input int exp);
        chk_req = 1'b1;
        chk_sel = sel[3:0];
        chk_exp = exp[15:0];
    endtask

    task automatic press_button(input int mask);
        i_btn = mask[2:0];
        step();
        i_btn = 3'b000;
        step();  // state moves at the edge ending the pulse
    endtask

    task automatic enter_shape(input int m, input int n);
        i_dims_valid = 1'b1;
        i_dim_m      = m[2:0];
        i_dim_n      = n[2:0];
        arm_check(SEL_EN_INPUT, 1);
        step();
        chk_req = 1'b0;
        while (!o_addr_ready) step();
    endtask

    task automatic pick_shape(input int m, input int n);
        if (picks < 2) begin
            pick_m[picks] = m;
            pick_n[picks] = n;
        end
        picks++;
        i_dims_valid = 1'b1;
        i_dim_m      = m[2:0];
        i_dim_n      = n[2:0];
        arm_check(SEL_TASK_MODE, TASK_SHAPE);
        step();
        chk_req      = 1'b0;
        i_dims_valid = 1'b0;
        step();  // filter cycle
    endtask

    task automatic give_id(input int id);
        i_id_val   = id[7:0];
        i_id_valid = 1'b1;
        arm_check(SEL_TASK_MODE, TASK_ID);
        step();
        chk_req    = 1'b0;
        i_id_valid = 1'b0;
        step();
    endtask

    task automatic pulse_input(input int which);
        i_dims_valid = 1'b0;
        case (which)
            5:       i_rx_done    = 1'b1;
            6:       i_error_flag = 1'b1;
            default: i_timeout    = 1'b1;
        endcase
        step();
        i_rx_done    = 1'b0;
        i_error_flag = 1'b0;
        i_timeout    = 1'b0;
    endtask

    task automatic request_check(input int sel, input int exp);
        arm_check(sel, exp);
        step();
        chk_req = 1'b0;
    endtask

    task automatic run_calc(input int latency);
        while (!o_start_calc) step();  // core request
        repeat (latency) step();
        i_calc_done = 1'b1;
        step();
        i_calc_done = 1'b0;
        if (picks == 2) begin  // two operands, second one went out as op2
            request_check(SEL_OP2_M, pick_m[1]);
            request_check(SEL_OP2_N, pick_n[1]);
        end
        picks = 0;
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int n;
        int err_mark;
        int tests;
        int failed;
        rst_n = 1'b0;
        i_sw = '0;
        i_btn = '0;
        i_dims_valid = 1'b0;
        i_dim_m = '0;
        i_dim_n = '0;
        i_rx_done = 1'b0;
        i_error_flag = 1'b0;
        i_timeout = 1'b0;
        i_id_val = '0;
        i_id_valid = 1'b0;
        i_calc_done = 1'b0;
        chk_req = 1'b0;
        chk_sel = '0;
        chk_exp = '0;
        err_mark = 0;
        tests = 0;
        failed = 0;
        load_commands(n);
        if (n < 0) begin
            $display("cannot open the test data file");
            $display(">>> FAIL");
            $finish;
        end else begin
            cycle_limit = CYCLES_PER_CMD * n;
            repeat (2) @(posedge clk);
            #2 rst_n = 1'b1;
            for (int i = 0; i < n; i++) begin
                case (cmd_op[i])
                    1: i_sw = cmd_a[i][7:0];
                    2: press_button(cmd_a[i]);
                    3: enter_shape(cmd_a[i], cmd_b[i]);
                    4: pick_shape(cmd_a[i], cmd_b[i]);
                    5, 6, 7: pulse_input(cmd_op[i]);
                    8: give_id(cmd_a[i]);
                    9: run_calc(cmd_a[i]);
                    10: request_check(cmd_a[i], cmd_b[i]);
                    0: begin
                        tests++;
                        picks = 0;
                        if (chk_errs == err_mark) begin
                            $display("test %0d done, ok", cmd_a[i]);
                        end else begin
                            failed++;
                            $display("test %0d done, %0d errors", cmd_a[i], chk_errs - err_mark);
                        end
                        err_mark = chk_errs;
                    end
                    default: $display("unknown command %0h skipped", cmd_op[i]);
                endcase
            end
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     tests, failed, chk_total, chk_errs);
            if (chk_errs == 0 && failed == 0) begin
                $display(">>> PASS");
            end else begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

/* tb/matrix_ctrl_testdata.txt */
# cmd a b in hex: 1 switches a, 2 button mask a, 3 input shape a x b, 4 operand shape a x b
# 5 rx done, 6 error flag, 7 timeout, 8 id a, 9 calc latency a, a check sel a exp b, 0 end test a
1 00 0
2 1 0
a 0 1
3 2 3
a 1 0
5 0 0
2 2 0
a 0 1
3 3 3
a 1 c
5 0 0
2 2 0
3 2 3
a 1 6
5 0 0
2 2 0
3 2 3
a 1 0
5 0 0
a 2 2
a 0 9
0 1 0
2 2 0
3 4 4
a 1 1e
a 2 3
6 0 0
a 2 2
3 3 2
a 1 1e
a 2 3
5 0 0
2 1 0
a 0 0
0 2 0
1 02 0
2 1 0
a 0 2
1 20 0
2 1 0
a 0 3
4 2 3
8 1 0
4 2 3
8 2 0
9 4 0
a 4 0
a 5 6
a 6 6
a 9 1
a 7 0
a 0 9
0 3 0
2 2 0
a 0 2
1 60 0
2 1 0
4 2 3
8 1 0
4 2 3
8 2 0
a 3 1
a 0 a
2 1 0
1 02 0
2 1 0
1 20 0
2 1 0
4 3 3
8 2 0
a 3 1
a 0 5
8 1 0
a 3 0
a 0 3
0 4 0
2 4 0
a 0 0
1 00 0
2 1 0
a 0 1
7 0 0
a 0 a
2 1 0
a 0 0
0 5 0
1 02 0
2 1 0
1 40 0
2 1 0
4 3 2
8 1 0
a 0 6
1 b0 0
2 1 0
9 3 0
a 8 b
a 4 1e
a a 3
a b 2
a 6 24
a 9 2
a 2 3
a 0 9
2 1 0
a 0 0
0 6 0

/* sim.f */
verilog/mcalc_pkg.sv
verilog/ledger_if.sv
verilog/key_edge_decoder.sv
verilog/matrix_ledger.sv
verilog/calc_sequencer.sv
verilog/matrix_ctrl_top.sv
tb/matrix_ctrl_checker.sv
tb/matrix_ctrl_properties.sv
tb/tb_matrix_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root
verilator --binary --timing --assert -f sim.f --top-module tb_matrix_ctrl -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
